/* periph_subsys.f */
logic/periph_map_pkg.sv
logic/periph_event_pkg.sv
logic/async_in_sync.sv
logic/periph_apb_decode.sv
logic/gpio_regs.sv
logic/tick_timer.sv
logic/fc_event_map.sv
logic/periph_subsys.sv
verification/tb_periph_subsys.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
TOP        := tb_periph_subsys
FILELIST   := periph_subsys.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Regression passed" $(LOG) || (echo "Simulation ended early"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/tb_periph_subsys.sv */
// Testbench for the peripheral subsystem
// Clock, reset, slow reference clock and APB access tasks
// Register model with a reference read function and an event compare process

`timescale 1ns/1ps

module tb_periph_subsys import periph_map_pkg::*, periph_event_pkg::*; ();

    localparam logic [FC_EVENT_W-1:0] EVT_USED = (32'd1 << EVT_DMA_PE) | (32'd1 << EVT_DMA_IRQ)
        | (32'd1 << EVT_TIMER) | (32'd1 << EVT_PF) | (32'd1 << EVT_REF_EDGE) | (32'd1 << EVT_GPIO);

    logic                  clk_i;
    logic                  rst_ni;
    logic                  slow_clk_i = 1'b0;
    logic [2:0]            slow_div = 3'd0;
    logic [APB_ADDR_W-1:0] paddr_i;
    logic [APB_DATA_W-1:0] pwdata_i;
    logic                  pwrite_i;
    logic                  psel_i;
    logic                  penable_i;
    logic [APB_DATA_W-1:0] prdata_o;
    logic                  pready_o;
    logic                  pslverr_o;
    logic [N_GPIO-1:0]     gpio_i;
    logic [N_GPIO-1:0]     gpio_out_o;
    logic [N_GPIO-1:0]     gpio_dir_o;
    logic                  dma_pe_evt_i;
    logic                  dma_pe_irq_i;
    logic                  pf_evt_i;
    logic [FC_EVENT_W-1:0] fc_events_o;

    // Register model
    logic [N_GPIO-1:0] m_dir;
    logic [N_GPIO-1:0] m_out;
    logic [N_GPIO-1:0] m_int_en;
    logic [N_GPIO-1:0] m_status;
    logic [N_GPIO-1:0] m_pins;
    logic              m_cfg;
    logic [31:0]       m_cmp;
    logic [31:0]       m_count;

    // Event tracking shared with the compare process
    logic        timer_on_m;
    logic        exp_timer;
    logic        ref_prev;
    logic [2:0]  pass_prev;
    int          edge_cnt;
    int          timer_hits;
    int          gpio_seen;
    int          gpio_expect;
    int          n_errors;
    int          polls;
    int          start_cnt;
    int          target;
    logic [31:0] rng;
    logic [31:0] rd_data;
    logic        rd_err;
    logic [31:0] cmp_n;

    periph_subsys uut (.*);

    always #20 clk_i = ~clk_i;

    // Slow reference clock, eight fast cycles per period
    always @(posedge clk_i) begin
        slow_div   <= slow_div + 3'd1;
        slow_clk_i <= slow_div[2];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] reg_addr(input logic [REGION_W-1:0] region,
                                             input logic [REGION_LSB-1:0] offset);
        return {{(APB_ADDR_W-REGION_W-REGION_LSB){1'b0}}, region, offset};
    endfunction

    function automatic logic unmapped(input logic [31:0] addr);
        return addr[REGION_LSB +: REGION_W] > 4'd1;
    endfunction

    function automatic logic [31:0] expected_read(input logic [31:0] addr);
        logic [REGION_W-1:0]   region;
        logic [REGION_LSB-1:0] offset;
        logic [31:0]           value;
        region = addr[REGION_LSB +: REGION_W];
        offset = addr[REGION_LSB-1:0];
        value  = '0;
        if (region == 4'd0) begin
            case (offset)
                GPIO_DIR:        value[N_GPIO-1:0] = m_dir;
                GPIO_IN:         value[N_GPIO-1:0] = m_pins;
                GPIO_OUT:        value[N_GPIO-1:0] = m_out;
                GPIO_INT_EN:     value[N_GPIO-1:0] = m_int_en;
                GPIO_INT_STATUS: value[N_GPIO-1:0] = m_status;
                default:         value = '0;
            endcase
        end else if (region == 4'd1) begin
            case (offset)
                TIMER_CFG:   value[0] = m_cfg;
                TIMER_COUNT: value = m_cfg ? m_count : '0;
                TIMER_CMP:   value = m_cmp;
                default:     value = '0;
            endcase
        end
        return value;
    endfunction

    function automatic void model_write(input logic [31:0] addr, input logic [31:0] data);
        if (addr[REGION_LSB +: REGION_W] == 4'd0) begin
            case (addr[REGION_LSB-1:0])
                GPIO_DIR:    m_dir    = data[N_GPIO-1:0];
                GPIO_OUT:    m_out    = data[N_GPIO-1:0];
                GPIO_INT_EN: m_int_en = data[N_GPIO-1:0];
                default:     ;
            endcase
        end else if (addr[REGION_LSB +: REGION_W] == 4'd1) begin
            case (addr[REGION_LSB-1:0])
                TIMER_CFG: m_cfg = data[0];
                TIMER_CMP: m_cmp = data;
                default:   ;
            endcase
        end
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] expected);
        n_errors++;
        $display("CHECK FAILED at %0d ns: %s, got 0x%08h, expected 0x%08h",
                 $time, what, got, expected);
        $display("Regression failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic abort_run(input string why);
        $display("ERROR at %0d ns: %s", $time, why);
        $display("Regression failed");
        $fatal(1, "Run aborted");
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_i);
    endtask

    // Setup cycle, then access cycle until pready
    task automatic apb_access(input logic [31:0] addr, input logic write,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int waits;
        @(posedge clk_i);
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        pwrite_i  <= write;
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        @(posedge clk_i);
        penable_i <= 1'b1;
        @(negedge clk_i);
        waits = 0;
        while (!pready_o && waits < 16) begin
            @(negedge clk_i);
            waits++;
        end
        if (!pready_o) begin
            abort_run("Timeout waiting for pready during an APB access");
        end
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic check_read(input logic [31:0] addr);
        logic [31:0] data;
        logic [31:0] expected;
        logic        err;
        expected = expected_read(addr);
        apb_access(addr, 1'b0, 32'd0, data, err);
        assert (data == expected)
            else report_mismatch($sformatf("read data at 0x%08h", addr), data, expected);
        assert (err == unmapped(addr))
            else report_mismatch($sformatf("pslverr on read at 0x%08h", addr),
                                 32'(err), 32'(unmapped(addr)));
        if (addr == reg_addr(4'd0, GPIO_INT_STATUS)) begin
            m_status = '0;
        end
    endtask

    task automatic check_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused_rdata;
        logic        err;
        apb_access(addr, 1'b1, data, unused_rdata, err);
        assert (err == unmapped(addr))
            else report_mismatch($sformatf("pslverr on write at 0x%08h", addr),
                                 32'(err), 32'(unmapped(addr)));
        model_write(addr, data);
    endtask

    task automatic check_all_regs();
        check_read(reg_addr(4'd0, GPIO_DIR));
        check_read(reg_addr(4'd0, GPIO_IN));
        check_read(reg_addr(4'd0, GPIO_OUT));
        check_read(reg_addr(4'd0, GPIO_INT_EN));
        check_read(reg_addr(4'd0, GPIO_INT_STATUS));
        check_read(reg_addr(4'd1, TIMER_CFG));
        check_read(reg_addr(4'd1, TIMER_COUNT));
        check_read(reg_addr(4'd1, TIMER_CMP));
    endtask

    task automatic check_pins();
        @(negedge clk_i);
        assert (gpio_dir_o == m_dir)
            else report_mismatch("gpio_dir_o", 32'(gpio_dir_o), 32'(m_dir));
        assert (gpio_out_o == m_out)
            else report_mismatch("gpio_out_o", 32'(gpio_out_o), 32'(m_out));
    endtask

    // Model follows the enable from the second edge after the write
    task automatic set_timer(input logic en);
        check_write(reg_addr(4'd1, TIMER_CFG), {31'd0, en});
        @(posedge clk_i);
        timer_on_m = en;
        m_count    = '0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Event compare process
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk_i) begin
        if (rst_ni) begin
            exp_timer = 1'b0;
            assert ((fc_events_o & ~EVT_USED) == '0)
                else report_mismatch("unused event bits", fc_events_o & ~EVT_USED, 32'd0);
            assert (fc_events_o[EVT_DMA_PE] == pass_prev[0])
                else report_mismatch("DMA event bit", 32'(fc_events_o[EVT_DMA_PE]),
                                     32'(pass_prev[0]));
            assert (fc_events_o[EVT_DMA_IRQ] == pass_prev[1])
                else report_mismatch("DMA interrupt bit", 32'(fc_events_o[EVT_DMA_IRQ]),
                                     32'(pass_prev[1]));
            assert (fc_events_o[EVT_PF] == pass_prev[2])
                else report_mismatch("prefetch event bit", 32'(fc_events_o[EVT_PF]),
                                     32'(pass_prev[2]));
            assert (!(fc_events_o[EVT_REF_EDGE] && ref_prev))
                else report_mismatch("reference edge pulse width", 32'd2, 32'd1);
            // Edges alternate and the first one after reset is a rise
            if (fc_events_o[EVT_REF_EDGE] && (edge_cnt % 2) == 0 && timer_on_m) begin
                if (m_count + 32'd1 == m_cmp) begin
                    exp_timer = 1'b1;
                    m_count   = '0;
                    timer_hits++;
                end else begin
                    m_count = m_count + 32'd1;
                end
            end
            if (fc_events_o[EVT_REF_EDGE]) begin
                edge_cnt++;
            end
            if (!timer_on_m) begin
                m_count = '0;
            end
            assert (fc_events_o[EVT_TIMER] == exp_timer)
                else report_mismatch("timer event bit", 32'(fc_events_o[EVT_TIMER]),
                                     32'(exp_timer));
            if (fc_events_o[EVT_GPIO]) begin
                assert (gpio_seen < gpio_expect)
                    else report_mismatch("GPIO event without an enabled rising pin",
                                         32'd1, 32'd0);
                gpio_seen++;
            end
            pass_prev = {pf_evt_i, dma_pe_irq_i, dma_pe_evt_i};
            ref_prev  = fc_events_o[EVT_REF_EDGE];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk_i        = 1'b0;
        rst_ni       = 1'b0;
        paddr_i      = '0;
        pwdata_i     = '0;
        pwrite_i     = 1'b0;
        psel_i       = 1'b0;
        penable_i    = 1'b0;
        gpio_i       = '0;
        dma_pe_evt_i = 1'b0;
        dma_pe_irq_i = 1'b0;
        pf_evt_i     = 1'b0;
        m_dir        = '0;
        m_out        = '0;
        m_int_en     = '0;
        m_status     = '0;
        m_pins       = '0;
        m_cfg        = 1'b0;
        m_cmp        = '0;
        m_count      = '0;
        timer_on_m   = 1'b0;
        exp_timer    = 1'b0;
        ref_prev     = 1'b0;
        pass_prev    = '0;
        edge_cnt     = 0;
        timer_hits   = 0;
        gpio_seen    = 0;
        gpio_expect  = 0;
        n_errors     = 0;
        rng          = 32'hb8d5_5f73;

        repeat (10) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        assert (fc_events_o == '0) else report_mismatch("fc_events_o after reset",
                                                        fc_events_o, 32'd0);
        assert (pslverr_o == 1'b0) else report_mismatch("pslverr_o after reset", 32'd1, 32'd0);
        check_pins();
        check_all_regs();

        // Direction, output and input registers
        rng = lcg_step(rng);
        check_write(reg_addr(4'd0, GPIO_DIR), 32'(rng[31:24]));
        rng = lcg_step(rng);
        check_write(reg_addr(4'd0, GPIO_OUT), 32'(rng[31:24]));
        check_read(reg_addr(4'd0, GPIO_DIR));
        check_read(reg_addr(4'd0, GPIO_OUT));
        check_pins();
        rng = lcg_step(rng);
        @(posedge clk_i);
        gpio_i <= rng[31:24];
        m_pins = rng[31:24];
        polls  = 0;
        apb_access(reg_addr(4'd0, GPIO_IN), 1'b0, 32'd0, rd_data, rd_err);
        while (rd_data != 32'(m_pins) && polls < 10) begin
            apb_access(reg_addr(4'd0, GPIO_IN), 1'b0, 32'd0, rd_data, rd_err);
            polls++;
        end
        if (rd_data != 32'(m_pins)) begin
            abort_run("Timeout waiting for GPIO_IN to follow the pins");
        end
        check_read(reg_addr(4'd0, GPIO_IN));

        // Per pin rising edge interrupts
        @(posedge clk_i);
        gpio_i <= '0;
        m_pins = '0;
        wait_cycles(8);
        rng = lcg_step(rng);
        check_write(reg_addr(4'd0, GPIO_INT_EN), 32'({rng[31:26], 2'b01}));
        check_read(reg_addr(4'd0, GPIO_INT_STATUS));
        for (int p = 0; p < N_GPIO; p++) begin
            @(posedge clk_i);
            m_pins[p] = 1'b1;
            gpio_i <= m_pins;
            if (m_int_en[p]) begin
                gpio_expect++;
                m_status[p] = 1'b1;
                polls = 0;
                while (gpio_seen != gpio_expect && polls < 20) begin
                    @(posedge clk_i);
                    polls++;
                end
                if (gpio_seen != gpio_expect) begin
                    abort_run("Timeout waiting for the GPIO event on fc_events_o");
                end
            end else begin
                wait_cycles(12);
            end
            check_read(reg_addr(4'd0, GPIO_INT_STATUS));
            check_read(reg_addr(4'd0, GPIO_INT_STATUS));
        end

        // Tick timer, disabled first
        wait_cycles(40);
        check_read(reg_addr(4'd1, TIMER_COUNT));
        rng   = lcg_step(rng);
        cmp_n = 32'd2 + {30'd0, rng[31:30]};
        check_write(reg_addr(4'd1, TIMER_CMP), cmp_n);
        check_read(reg_addr(4'd1, TIMER_CMP));
        set_timer(1'b1);
        check_read(reg_addr(4'd1, TIMER_CFG));
        target = timer_hits + 3;
        polls  = 0;
        while (timer_hits < target && polls < 200) begin
            @(posedge clk_i);
            polls++;
        end
        if (timer_hits < target) begin
            abort_run("Timeout waiting for timer compare events");
        end
        set_timer(1'b0);
        check_read(reg_addr(4'd1, TIMER_COUNT));
        check_read(reg_addr(4'd1, TIMER_CFG));
        wait_cycles(40);

        // Reference edges and pass-through events
        start_cnt = edge_cnt;
        wait_cycles(32);
        assert (edge_cnt - start_cnt == 8)
            else report_mismatch("reference edges in four slow periods",
                                 32'(edge_cnt - start_cnt), 32'd8);
        for (int i = 0; i < 24; i++) begin
            @(posedge clk_i);
            rng = lcg_step(rng);
            dma_pe_evt_i <= rng[31];
            dma_pe_irq_i <= rng[30];
            pf_evt_i     <= rng[29];
        end
        @(posedge clk_i);
        dma_pe_evt_i <= 1'b0;
        dma_pe_irq_i <= 1'b0;
        pf_evt_i     <= 1'b0;
        wait_cycles(4);

        // Unmapped regions answer with an error and change nothing
        for (int r = 2; r < 16; r += 3) begin
            rng = lcg_step(rng);
            check_write(reg_addr(4'(r), 8'h00), rng | 32'd1);
            check_write(reg_addr(4'(r), 8'h08), rng);
            check_read(reg_addr(4'(r), 8'h0C));
        end
        check_all_regs();
        check_pins();

        wait_cycles(4);
        if (n_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* logic/periph_subsys.sv */
// Peripheral subsystem top level
// APB slave with GPIO and tick timer regions
// Input synchronizer and registered fabric controller event vector

`timescale 1ns/1ps

module periph_subsys import periph_map_pkg::*, periph_event_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  slow_clk_i,
    input  logic [APB_ADDR_W-1:0] paddr_i,
    input  logic [APB_DATA_W-1:0] pwdata_i,
    input  logic                  pwrite_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    output logic [APB_DATA_W-1:0] prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    input  logic [N_GPIO-1:0]     gpio_i,
    output logic [N_GPIO-1:0]     gpio_out_o,
    output logic [N_GPIO-1:0]     gpio_dir_o,
    input  logic                  dma_pe_evt_i,
    input  logic                  dma_pe_irq_i,
    input  logic                  pf_evt_i,
    output logic [FC_EVENT_W-1:0] fc_events_o
);

    logic [N_GPIO-1:0]     gpio_sync;
    logic [N_GPIO-1:0]     gpio_rise;
    logic                  ref_rise;
    logic                  ref_fall;
    logic                  gpio_sel;
    logic                  timer_sel;
    logic [APB_DATA_W-1:0] gpio_rdata;
    logic [APB_DATA_W-1:0] timer_rdata;
    logic                  gpio_evt;
    logic                  timer_evt;

    ////////////////////////////////////////////////////////////////////////////
    // Input side
    ////////////////////////////////////////////////////////////////////////////

    async_in_sync i_in_sync (
        .clk_i       ( clk_i      ),
        .rst_ni      ( rst_ni     ),
        .slow_clk_i  ( slow_clk_i ),
        .gpio_i      ( gpio_i     ),
        .gpio_sync_o ( gpio_sync  ),
        .gpio_rise_o ( gpio_rise  ),
        .ref_rise_o  ( ref_rise   ),
        .ref_fall_o  ( ref_fall   )
    );

    ////////////////////////////////////////////////////////////////////////////
    // Bus decode and register blocks
    ////////////////////////////////////////////////////////////////////////////

    periph_apb_decode i_decode (
        .paddr_i       ( paddr_i     ),
        .psel_i        ( psel_i      ),
        .gpio_rdata_i  ( gpio_rdata  ),
        .timer_rdata_i ( timer_rdata ),
        .gpio_sel_o    ( gpio_sel    ),
        .timer_sel_o   ( timer_sel   ),
        .prdata_o      ( prdata_o    ),
        .pready_o      ( pready_o    ),
        .pslverr_o     ( pslverr_o   )
    );

    gpio_regs i_gpio (
        .clk_i       ( clk_i      ),
        .rst_ni      ( rst_ni     ),
        .sel_i       ( gpio_sel   ),
        .penable_i   ( penable_i  ),
        .pwrite_i    ( pwrite_i   ),
        .paddr_i     ( paddr_i    ),
        .pwdata_i    ( pwdata_i   ),
        .gpio_sync_i ( gpio_sync  ),
        .gpio_rise_i ( gpio_rise  ),
        .rdata_o     ( gpio_rdata ),
        .gpio_out_o  ( gpio_out_o ),
        .gpio_dir_o  ( gpio_dir_o ),
        .gpio_evt_o  ( gpio_evt   )
    );

    tick_timer i_timer (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .sel_i       ( timer_sel   ),
        .penable_i   ( penable_i   ),
        .pwrite_i    ( pwrite_i    ),
        .paddr_i     ( paddr_i     ),
        .pwdata_i    ( pwdata_i    ),
        .ref_rise_i  ( ref_rise    ),
        .rdata_o     ( timer_rdata ),
        .timer_evt_o ( timer_evt   )
    );

    ////////////////////////////////////////////////////////////////////////////
    // Output side
    ////////////////////////////////////////////////////////////////////////////

    fc_event_map i_event_map (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .dma_pe_evt_i ( dma_pe_evt_i ),
        .dma_pe_irq_i ( dma_pe_irq_i ),
        .pf_evt_i     ( pf_evt_i     ),
        .timer_evt_i  ( timer_evt    ),
        .ref_rise_i   ( ref_rise     ),
        .ref_fall_i   ( ref_fall     ),
        .gpio_evt_i   ( gpio_evt     ),
        .fc_events_o  ( fc_events_o  )
    );

endmodule

/* logic/fc_event_map.sv */
// Fabric controller event vector assembly
// All sources are registered once at their fixed bit positions

`timescale 1ns/1ps

module fc_event_map import periph_event_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  dma_pe_evt_i,
    input  logic                  dma_pe_irq_i,
    input  logic                  pf_evt_i,
    input  logic                  timer_evt_i,
    input  logic                  ref_rise_i,
    input  logic                  ref_fall_i,
    input  logic                  gpio_evt_i,
    output logic [FC_EVENT_W-1:0] fc_events_o
);

    logic [FC_EVENT_W-1:0] events_d;

    // Unlisted bits stay zero
    always_comb begin
        events_d               = '0;
        events_d[EVT_DMA_PE]   = dma_pe_evt_i;
        events_d[EVT_DMA_IRQ]  = dma_pe_irq_i;
        events_d[EVT_TIMER]    = timer_evt_i;
        events_d[EVT_PF]       = pf_evt_i;
        events_d[EVT_REF_EDGE] = ref_rise_i | ref_fall_i;
        events_d[EVT_GPIO]     = gpio_evt_i;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fc_events_o <= '0;
        end else begin
            fc_events_o <= events_d;
        end
    end

endmodule

/* logic/tick_timer.sv */
// Tick timer counting rising edges of the slow reference clock
// Compare match raises a one cycle event and restarts the count

`timescale 1ns/1ps

module tick_timer import periph_map_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  sel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [APB_ADDR_W-1:0] paddr_i,
    input  logic [APB_DATA_W-1:0] pwdata_i,
    input  logic                  ref_rise_i,
    output logic [APB_DATA_W-1:0] rdata_o,
    output logic                  timer_evt_o
);

    timer_reg_e            reg_sel;
    logic                  wr_en;
    logic                  cfg_wr;
    logic                  enable_q;
    logic [APB_DATA_W-1:0] count_q;
    logic [APB_DATA_W-1:0] cmp_q;
    logic [APB_DATA_W-1:0] count_inc;
    logic                  hit;

    assign reg_sel = timer_reg_e'(paddr_i[REGION_LSB-1:0]);
    assign wr_en   = sel_i && penable_i && pwrite_i;
    assign cfg_wr  = wr_en && (reg_sel == TIMER_CFG);

    assign count_inc   = count_q + 1'b1;
    assign hit         = enable_q && ref_rise_i && (count_inc == cmp_q);
    assign timer_evt_o = hit;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q <= 1'b0;
            cmp_q    <= '0;
        end else if (wr_en) begin
            if (reg_sel == TIMER_CFG) begin
                enable_q <= pwdata_i[0];
            end
            if (reg_sel == TIMER_CMP) begin
                cmp_q <= pwdata_i;
            end
        end
    end

    // Writing the config restarts the count from zero
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (cfg_wr || !enable_q || hit) begin
            count_q <= '0;
        end else if (ref_rise_i) begin
            count_q <= count_inc;
        end
    end

    always_comb begin
        case (reg_sel)
            TIMER_CFG:   rdata_o = {{(APB_DATA_W-1){1'b0}}, enable_q};
            TIMER_COUNT: rdata_o = count_q;
            TIMER_CMP:   rdata_o = cmp_q;
            default:     rdata_o = '0;
        endcase
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni) timer_evt_o |-> enable_q);

endmodule

/* logic/gpio_regs.sv */
// GPIO register block on the APB bus
// Direction, output, input, interrupt enable and sticky interrupt status
// Per pin rising edge interrupt with a single event output

`timescale 1ns/1ps

module gpio_regs import periph_map_pkg::*, periph_event_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  sel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [APB_ADDR_W-1:0] paddr_i,
    input  logic [APB_DATA_W-1:0] pwdata_i,
    input  logic [N_GPIO-1:0]     gpio_sync_i,
    input  logic [N_GPIO-1:0]     gpio_rise_i,
    output logic [APB_DATA_W-1:0] rdata_o,
    output logic [N_GPIO-1:0]     gpio_out_o,
    output logic [N_GPIO-1:0]     gpio_dir_o,
    output logic                  gpio_evt_o
);

    gpio_reg_e         reg_sel;
    logic              wr_en;
    logic              rd_en;
    logic              status_clr;
    logic [N_GPIO-1:0] dir_q;
    logic [N_GPIO-1:0] out_q;
    logic [N_GPIO-1:0] int_en_q;
    logic [N_GPIO-1:0] status_q;
    logic [N_GPIO-1:0] new_irq;

    assign reg_sel = gpio_reg_e'(paddr_i[REGION_LSB-1:0]);
    assign wr_en   = sel_i && penable_i && pwrite_i;
    assign rd_en   = sel_i && penable_i && !pwrite_i;

    // Status is cleared by reading it
    assign status_clr = rd_en && (reg_sel == GPIO_INT_STATUS);

    ////////////////////////////////////////////////////////////////////////////
    // Configuration registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dir_q    <= '0;
            out_q    <= '0;
            int_en_q <= '0;
        end else if (wr_en) begin
            case (reg_sel)
                GPIO_DIR:    dir_q    <= pwdata_i[N_GPIO-1:0];
                GPIO_OUT:    out_q    <= pwdata_i[N_GPIO-1:0];
                GPIO_INT_EN: int_en_q <= pwdata_i[N_GPIO-1:0];
                default:     ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Interrupt status
    ////////////////////////////////////////////////////////////////////////////

    assign new_irq    = gpio_rise_i & int_en_q;
    assign gpio_evt_o = |new_irq;

    // An edge in the clearing cycle still lands in the status
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            status_q <= '0;
        end else begin
            status_q <= (status_clr ? '0 : status_q) | new_irq;
        end
    end

    always_comb begin
        rdata_o = '0;
        case (reg_sel)
            GPIO_DIR:        rdata_o[N_GPIO-1:0] = dir_q;
            GPIO_IN:         rdata_o[N_GPIO-1:0] = gpio_sync_i;
            GPIO_OUT:        rdata_o[N_GPIO-1:0] = out_q;
            GPIO_INT_EN:     rdata_o[N_GPIO-1:0] = int_en_q;
            GPIO_INT_STATUS: rdata_o[N_GPIO-1:0] = status_q;
            default:         rdata_o = '0;
        endcase
    end

    assign gpio_out_o = out_q;
    assign gpio_dir_o = dir_q;

    // Every event leaves a pending bit behind, even across a status read
    assert property (@(posedge clk_i) disable iff (!rst_ni) gpio_evt_o |=> (status_q != '0));

endmodule

/* logic/periph_apb_decode.sv */
// APB region decoder for the GPIO and timer blocks
// Select steering, read data mux and error response for unmapped regions

`timescale 1ns/1ps

module periph_apb_decode import periph_map_pkg::*; (
    input  logic [APB_ADDR_W-1:0] paddr_i,
    input  logic                  psel_i,
    input  logic [APB_DATA_W-1:0] gpio_rdata_i,
    input  logic [APB_DATA_W-1:0] timer_rdata_i,
    output logic                  gpio_sel_o,
    output logic                  timer_sel_o,
    output logic [APB_DATA_W-1:0] prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o
);

    logic [REGION_W-1:0] region_field;
    apb_region_e         region;

    assign region_field = paddr_i[REGION_LSB +: REGION_W];

    // Only fields 0 and 1 are mapped
    always_comb begin
        case (region_field)
            REGION_GPIO:  region = REGION_GPIO;
            REGION_TIMER: region = REGION_TIMER;
            default:      region = REGION_NONE;
        endcase
    end

    assign gpio_sel_o  = psel_i && (region == REGION_GPIO);
    assign timer_sel_o = psel_i && (region == REGION_TIMER);

    // Response mux
    always_comb begin
        case (region)
            REGION_GPIO:  prdata_o = gpio_rdata_i;
            REGION_TIMER: prdata_o = timer_rdata_i;
            default:      prdata_o = '0;
        endcase
    end

    // Zero wait slave
    assign pready_o  = 1'b1;
    assign pslverr_o = psel_i && (region == REGION_NONE);

    // Never more than one block selected
    always_comb begin
        assert final (!(gpio_sel_o && timer_sel_o));
    end

endmodule

/* logic/async_in_sync.sv */
// Input synchronizer for the slow reference clock and the GPIO pins
// Two flop synchronizer followed by an edge detect stage

`timescale 1ns/1ps

module async_in_sync import periph_event_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              slow_clk_i,
    input  logic [N_GPIO-1:0] gpio_i,
    output logic [N_GPIO-1:0] gpio_sync_o,
    output logic [N_GPIO-1:0] gpio_rise_o,
    output logic              ref_rise_o,
    output logic              ref_fall_o
);

    // Slow clock rides in the top bit next to the pins
    logic [N_GPIO:0] meta_q;
    logic [N_GPIO:0] sync_q;
    logic [N_GPIO:0] prev_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            meta_q <= '0;
            sync_q <= '0;
            prev_q <= '0;
        end else begin
            meta_q <= {slow_clk_i, gpio_i};
            sync_q <= meta_q;
            prev_q <= sync_q;
        end
    end

    assign gpio_sync_o = sync_q[N_GPIO-1:0];
    assign gpio_rise_o = sync_q[N_GPIO-1:0] & ~prev_q[N_GPIO-1:0];
    assign ref_rise_o  = sync_q[N_GPIO] & ~prev_q[N_GPIO];
    assign ref_fall_o  = ~sync_q[N_GPIO] & prev_q[N_GPIO];

    // A reference edge is either rising or falling in any cycle
    assert property (@(posedge clk_i) disable iff (!rst_ni) !(ref_rise_o && ref_fall_o));

endmodule

/* logic/periph_event_pkg.sv */
// Event side constants of the peripheral subsystem
// GPIO pin count, event vector width and fixed event bit positions

package periph_event_pkg;

    // Number of GPIO pins
    localparam int N_GPIO = 8;

    // Width of the fabric controller event vector
    localparam int FC_EVENT_W = 32;

    // Bit positions in the event vector
    // Bits 7..0 stay reserved for software events
    localparam int EVT_DMA_PE   = 8;
    localparam int EVT_DMA_IRQ  = 9;
    localparam int EVT_TIMER    = 10;
    localparam int EVT_PF       = 12;
    localparam int EVT_REF_EDGE = 14;
    localparam int EVT_GPIO     = 15;

endpackage

/* logic/periph_map_pkg.sv */
// APB address map of the peripheral subsystem
// Bus widths, region field position and the decoded region enum
// Word offsets of the GPIO and timer register blocks

package periph_map_pkg;

    // APB bus widths
    localparam int APB_ADDR_W = 32;
    localparam int APB_DATA_W = 32;

    // Region field sits above the register offset
    localparam int REGION_LSB = 8;
    localparam int REGION_W   = 4;

    typedef enum logic [REGION_W-1:0] {
        REGION_GPIO  = 4'h0,
        REGION_TIMER = 4'h1,
        REGION_NONE  = 4'hF
    } apb_region_e;

    // GPIO register offsets
    typedef enum logic [REGION_LSB-1:0] {
        GPIO_DIR        = 8'h00,
        GPIO_IN         = 8'h04,
        GPIO_OUT        = 8'h08,
        GPIO_INT_EN     = 8'h0C,
        GPIO_INT_STATUS = 8'h10
    } gpio_reg_e;

    // Timer register offsets
    typedef enum logic [REGION_LSB-1:0] {
        TIMER_CFG   = 8'h00,
        TIMER_COUNT = 8'h04,
        TIMER_CMP   = 8'h08
    } timer_reg_e;

endpackage
